// ==== compile.f ====
+incdir+src
src/streamer_pkg.sv
src/streamer_fsm.sv
src/stream_addressgen.sv
src/stream_fifo.sv
src/load_channel.sv
src/tcdm_arbiter.sv
src/streamer_top.sv
testbench/tb_mem_model.sv
testbench/tb_streamer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the streamer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_streamer -o sim_streamer

output=$(./obj_dir/sim_streamer)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
else
  exit 1
fi

// ==== testbench/tb_streamer.sv ====
// Streamer testbench with a job table, an engine model, memory checks and a timeout
`timescale 1ns/1ps
`include "streamer_config.svh"

module tb_streamer
  import streamer_pkg::*;
();

  typedef struct {
    string       name;
    chan_cfg_t   x;
    chan_cfg_t   w;
    chan_cfg_t   z;
    logic        zp;
    int          hold;
    logic [31:0] zseed;
    logic [3:0]  zstrb;
  } row_t;

  localparam int NUM_ROWS = 5;

  logic clk_i, reset_i, start_i, busy_o, done_o;
  logic x_valid_o, x_credit_i, w_valid_o, w_credit_i, z_valid_i, z_credit_o;
  streamer_job_t job_i;
  load_beat_t    x_beat_o, w_beat_o;
  store_beat_t   z_beat_i;
  mem_req_t      mem_req_o;
  mem_rsp_t      mem_rsp_i;

  row_t        rows [NUM_ROWS];
  logic [31:0] exp_x [0:63];
  logic [31:0] exp_w [0:63];
  string       cur_name;
  int          cur_hold, cur_xlen, cur_wlen, cur_zlen, x_idx, w_idx, z_pushed;
  int          x_pending, w_pending, x_timer, w_timer, z_credits;
  int          data_errors, proto_errors, cycles, limit, zcred_total, done_total;
  logic        z_enable, in_job;
  logic [31:0] cur_zseed;
  logic [3:0]  cur_zstrb;

  streamer_top uut (.*);
  tb_mem_model mem (.clk_i(clk_i), .reset_i(reset_i), .req_i(mem_req_o), .rsp_o(mem_rsp_i));

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] fill_word(input logic [15:0] a);
    return {~a, a ^ 16'h5A3C};
  endfunction

  function automatic logic [31:0] z_word(input logic [31:0] seed, input int i);
    return seed + 32'(i) * 32'h01030507;
  endfunction

  function automatic logic [3:0] z_strobe(input logic [3:0] s, input int i);
    logic [7:0] both;
    both = {s, s} >> (i % 4);
    return both[3:0];
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_beat(input string label, input int idx, input int len,
                            input logic [31:0] exp, input load_beat_t got);
    assert (idx < len) else begin
      $display("%s %s stream delivered a beat beyond its length", cur_name, label);
      proto_errors++;
    end
    if (idx < len) begin
      assert (got.data == exp) else begin
        $display("MISMATCH %s %s[%0d] data expected %h actual %h", cur_name, label, idx, exp,
                 got.data);
        data_errors++;
      end
      assert (got.last == (idx == len - 1)) else begin
        $display("MISMATCH %s %s[%0d] last expected %0b actual %0b", cur_name, label, idx,
                 idx == len - 1, got.last);
        data_errors++;
      end
    end
  endtask

  // Engine model that takes load beats, returns credits after the hold time and pushes Z beats
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (x_valid_o) begin
        check_beat("x", x_idx, cur_xlen, exp_x[x_idx & 63], x_beat_o);
        x_idx++;
        x_pending++;
      end
      if (w_valid_o) begin
        check_beat("w", w_idx, cur_wlen, exp_w[w_idx & 63], w_beat_o);
        w_idx++;
        w_pending++;
      end
      assert (x_pending <= `ENGINE_CREDITS && w_pending <= `ENGINE_CREDITS) else begin
        $display("%s load stream exceeded its engine credits", cur_name);
        proto_errors++;
      end
      x_credit_i <= 1'b0;
      w_credit_i <= 1'b0;
      if (x_pending > 0 && x_timer == 0) begin
        x_credit_i <= 1'b1;
        x_pending--;
        x_timer = cur_hold;
      end else if (x_timer > 0) x_timer--;
      if (w_pending > 0 && w_timer == 0) begin
        w_credit_i <= 1'b1;
        w_pending--;
        w_timer = cur_hold;
      end else if (w_timer > 0) w_timer--;
      z_credits = z_credits + int'(z_credit_o);
      z_valid_i <= 1'b0;
      if (z_enable && z_pushed < cur_zlen && z_credits > 0) begin
        z_valid_i <= 1'b1;
        z_beat_i  <= '{data: z_word(cur_zseed, z_pushed), strb: z_strobe(cur_zstrb, z_pushed)};
        z_pushed++;
        z_credits--;
      end
    end
  end

  // Protocol monitor for done, busy and store credits
  always @(posedge clk_i) begin
    if (!reset_i) begin
      cycles++;
      if (z_credit_o) zcred_total++;
      if (done_o) done_total++;
      assert (in_job || !done_o) else begin
        $display("done pulse seen outside a job");
        proto_errors++;
      end
      if (in_job) begin
        assert (busy_o) else begin
          $display("%s busy dropped during the job", cur_name);
          proto_errors++;
        end
      end
      if (start_i) in_job = 1'b1;
      else if (done_o) in_job = 1'b0;
      if (cycles > limit) begin
        $display("Timeout after %0d cycles, the job did not finish", cycles);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  task automatic run_row(input row_t r);
    int          zc0, d0;
    logic [15:0] a;
    logic [15:0] lo;
    logic [15:0] hi;
    logic [31:0] exp;
    logic [31:0] got;
    for (int i = 0; i < 2048; i++) mem.words[i] = fill_word(16'(i));
    cur_name = r.name;
    cur_hold = r.hold;
    cur_xlen = int'(r.x.len);
    cur_wlen = int'(r.w.len);
    cur_zlen = int'(r.z.len);
    cur_zseed = r.zseed;
    cur_zstrb = r.zstrb;
    for (int i = 0; i < cur_xlen; i++) exp_x[i] = fill_word(r.x.base + 16'(i) * r.x.stride);
    for (int i = 0; i < cur_wlen; i++) exp_w[i] = fill_word(r.w.base + 16'(i) * r.w.stride);
    x_idx = 0;
    w_idx = 0;
    z_pushed = 0;
    zc0 = zcred_total;
    d0 = done_total;
    @(posedge clk_i);
    start_i  <= 1'b1;
    job_i    <= '{x: r.x, w: r.w, z: r.z, z_priority: r.zp};
    z_enable <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    while (done_total == d0) @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    z_enable <= 1'b0;
    assert (x_idx == cur_xlen && w_idx == cur_wlen) else begin
      $display("%s loads incomplete, x %0d of %0d, w %0d of %0d", r.name, x_idx, cur_xlen,
               w_idx, cur_wlen);
      proto_errors++;
    end
    assert (zcred_total - zc0 == cur_zlen) else begin
      $display("MISMATCH %s z credits expected %0d actual %0d", r.name, cur_zlen,
               zcred_total - zc0);
      data_errors++;
    end
    assert (done_total - d0 == 1) else begin
      $display("%s done pulsed %0d times", r.name, done_total - d0);
      proto_errors++;
    end
    lo = r.z.base - 16'd2;
    hi = r.z.base + r.z.len * r.z.stride + 16'd2;
    for (logic [15:0] t = lo; t != hi; t++) begin
      exp = fill_word(t);
      for (int i = 0; i < cur_zlen; i++) begin
        a = r.z.base + 16'(i) * r.z.stride;
        if (a == t) exp = merge_bytes(fill_word(t), z_word(r.zseed, i), z_strobe(r.zstrb, i));
      end
      got = mem.words[t];
      assert (got == exp) else begin
        $display("MISMATCH %s mem[%h] expected %h actual %h", r.name, t, exp, got);
        data_errors++;
      end
    end
  endtask

  initial begin
    reset_i = 1'b1;
    start_i = 1'b0;
    job_i = '0;
    x_credit_i = 1'b0;
    w_credit_i = 1'b0;
    z_valid_i = 1'b0;
    z_beat_i = '0;
    z_enable = 1'b0;
    in_job = 1'b0;
    z_credits = `STORE_FIFO_DEPTH;
    {x_pending, w_pending, x_timer, w_timer, data_errors, proto_errors} = '0;
    {cycles, zcred_total, done_total} = '0;
    rows[0] = '{"basic", '{16'h100, 16'd1, 16'd8}, '{16'h200, 16'd2, 16'd6},
                '{16'h400, 16'd1, 16'd5}, 1'b0, 0, 32'h11223344, 4'hF};
    rows[1] = '{"z_first", '{16'h100, 16'd1, 16'd8}, '{16'h200, 16'd2, 16'd6},
                '{16'h400, 16'd1, 16'd5}, 1'b1, 0, 32'h11223344, 4'hF};
    rows[2] = '{"w_empty", '{16'h120, 16'd3, 16'd7}, '{16'h220, 16'd1, 16'd0},
                '{16'h420, 16'd2, 16'd4}, 1'b0, 0, 32'hCAFE0001, 4'h5};
    rows[3] = '{"held_credits", '{16'h140, 16'd1, 16'd10}, '{16'h240, 16'd4, 16'd9},
                '{16'h440, 16'd3, 16'd6}, 1'b1, 6, 32'h0BADF00D, 4'hA};
    rows[4] = '{"long_run", '{16'h160, 16'd2, 16'd12}, '{16'h260, 16'd1, 16'd12},
                '{16'h460, 16'd1, 16'd8}, 1'b0, 2, 32'h5EED0043, 4'h3};
    limit = 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit += 20 * int'(rows[r].x.len + rows[r].w.len + rows[r].z.len);
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    assert (!mem_req_o.req && !x_valid_o && !w_valid_o && !z_credit_o && !busy_o && !done_o)
    else begin
      $display("Outputs active after reset");
      proto_errors++;
    end
    for (int r = 0; r < NUM_ROWS; r++) run_row(rows[r]);
    $display("Errors: data %0d, protocol %0d", data_errors, proto_errors);
    if (data_errors == 0 && proto_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_mem_model.sv ====
// Memory model for the streamer testbench with random grant stalls and one-cycle reads
`timescale 1ns/1ps
`include "streamer_config.svh"

module tb_mem_model
  import streamer_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  logic [`STREAMER_DW-1:0] words [0:(1 << `STREAMER_AW) - 1];
  logic                    ready_q;
  logic                    r_valid_q;
  logic [`STREAMER_DW-1:0] r_data_q;
  integer                  seed = 43;

  // Grant for this cycle is drawn at the previous edge with a chance of three in four
  assign rsp_o.gnt     = req_i.req & ready_q;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_data  = r_data_q;

  always @(posedge clk_i) begin
    if (reset_i) begin
      ready_q   <= 1'b0;
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
    end else begin
      ready_q   <= (($random(seed) & 3) != 0);
      r_valid_q <= rsp_o.gnt & req_i.wen;
      if (rsp_o.gnt && req_i.wen) begin
        r_data_q <= words[req_i.addr];
      end
      // Writes land under their byte strobes
      if (rsp_o.gnt && !req_i.wen) begin
        for (int b = 0; b < `STREAMER_BW; b++) begin
          if (req_i.be[b]) begin
            words[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== src/streamer_top.sv ====
// Streamer top level joining the job FSM, address generators, channels and arbiter
`timescale 1ns/1ps
`include "streamer_config.svh"

module streamer_top
  import streamer_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          start_i,
  input  streamer_job_t job_i,
  output logic          busy_o,
  output logic          done_o,
  output load_beat_t    x_beat_o,
  output logic          x_valid_o,
  input  logic          x_credit_i,
  output load_beat_t    w_beat_o,
  output logic          w_valid_o,
  input  logic          w_credit_i,
  input  store_beat_t   z_beat_i,
  input  logic          z_valid_i,
  output logic          z_credit_o,
  output mem_req_t      mem_req_o,
  input  mem_rsp_t      mem_rsp_i
);

  logic                    run;
  logic                    clear;
  logic                    z_priority_q;
  logic [`STREAMER_AW-1:0] x_addr, w_addr, z_addr;
  logic                    x_active, w_active, z_active;
  logic                    x_last, w_last;
  logic                    x_finished, w_finished, z_finished;
  logic                    x_can_issue, w_can_issue;
  logic                    x_drained, w_drained;
  logic                    x_req, w_req, z_req;
  logic                    x_gnt, w_gnt, z_gnt;
  logic                    x_rsp, w_rsp;
  logic                    z_empty;
  store_beat_t             z_head;

  streamer_fsm i_fsm (
    .clk_i           ( clk_i                 ),
    .reset_i         ( reset_i               ),
    .start_i         ( start_i               ),
    .x_finished_i    ( x_finished            ),
    .w_finished_i    ( w_finished            ),
    .z_finished_i    ( z_finished            ),
    .loads_drained_i ( x_drained & w_drained ),
    .run_o           ( run                   ),
    .clear_o         ( clear                 ),
    .busy_o          ( busy_o                ),
    .done_o          ( done_o                )
  );

  // Priority bit is taken with the rest of the job on start
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      z_priority_q <= 1'b0;
    end else if (clear) begin
      z_priority_q <= job_i.z_priority;
    end
  end

  stream_addressgen i_x_addr (
    .clk_i, .reset_i, .clear_i ( clear ), .run_i ( run ), .cfg_i ( job_i.x ),
    .advance_i ( x_gnt ), .addr_o ( x_addr ), .active_o ( x_active ),
    .last_o ( x_last ), .finished_o ( x_finished )
  );

  stream_addressgen i_w_addr (
    .clk_i, .reset_i, .clear_i ( clear ), .run_i ( run ), .cfg_i ( job_i.w ),
    .advance_i ( w_gnt ), .addr_o ( w_addr ), .active_o ( w_active ),
    .last_o ( w_last ), .finished_o ( w_finished )
  );

  stream_addressgen i_z_addr (
    .clk_i, .reset_i, .clear_i ( clear ), .run_i ( run ), .cfg_i ( job_i.z ),
    .advance_i ( z_gnt ), .addr_o ( z_addr ), .active_o ( z_active ),
    .last_o ( ), .finished_o ( z_finished )
  );

  load_channel i_x_load (
    .clk_i, .reset_i, .clear_i ( clear ), .issue_i ( x_gnt ), .issue_last_i ( x_last ),
    .rsp_valid_i ( x_rsp ), .rsp_data_i ( mem_rsp_i.r_data ), .can_issue_o ( x_can_issue ),
    .beat_o ( x_beat_o ), .valid_o ( x_valid_o ), .credit_i ( x_credit_i ),
    .drained_o ( x_drained )
  );

  load_channel i_w_load (
    .clk_i, .reset_i, .clear_i ( clear ), .issue_i ( w_gnt ), .issue_last_i ( w_last ),
    .rsp_valid_i ( w_rsp ), .rsp_data_i ( mem_rsp_i.r_data ), .can_issue_o ( w_can_issue ),
    .beat_o ( w_beat_o ), .valid_o ( w_valid_o ), .credit_i ( w_credit_i ),
    .drained_o ( w_drained )
  );

  // Store beats pushed before the job runs wait here for the Z addresses
  stream_fifo #(
    .T     ( store_beat_t      ),
    .DEPTH ( `STORE_FIFO_DEPTH )
  ) i_store_fifo (
    .clk_i, .reset_i, .clear_i ( 1'b0 ), .push_i ( z_valid_i ), .data_i ( z_beat_i ),
    .pop_i ( z_gnt ), .data_o ( z_head ), .empty_o ( z_empty ), .full_o ( )
  );

  assign x_req = x_active & x_can_issue;
  assign w_req = w_active & w_can_issue;
  assign z_req = z_active & ~z_empty;

  tcdm_arbiter i_arbiter (
    .clk_i, .reset_i, .z_priority_i ( z_priority_q ),
    .x_req_i ( x_req ), .w_req_i ( w_req ), .x_addr_i ( x_addr ), .w_addr_i ( w_addr ),
    .z_req_i ( z_req ), .z_addr_i ( z_addr ), .z_beat_i ( z_head ),
    .mem_req_o ( mem_req_o ), .mem_rsp_i ( mem_rsp_i ),
    .x_gnt_o ( x_gnt ), .w_gnt_o ( w_gnt ), .z_gnt_o ( z_gnt ),
    .x_rsp_o ( x_rsp ), .w_rsp_o ( w_rsp )
  );

  // Each granted store frees one engine slot
  assign z_credit_o = z_gnt;

endmodule

// ==== src/tcdm_arbiter.sv ====
// Memory port arbiter for the X, W and Z channels with read response routing
`timescale 1ns/1ps
`include "streamer_config.svh"

module tcdm_arbiter
  import streamer_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    z_priority_i,
  input  logic                    x_req_i,
  input  logic                    w_req_i,
  input  logic [`STREAMER_AW-1:0] x_addr_i,
  input  logic [`STREAMER_AW-1:0] w_addr_i,
  input  logic                    z_req_i,
  input  logic [`STREAMER_AW-1:0] z_addr_i,
  input  store_beat_t             z_beat_i,
  output mem_req_t                mem_req_o,
  input  mem_rsp_t                mem_rsp_i,
  output logic                    x_gnt_o,
  output logic                    w_gnt_o,
  output logic                    z_gnt_o,
  output logic                    x_rsp_o,
  output logic                    w_rsp_o
);

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_X,
    SEL_W,
    SEL_Z
  } sel_e;

  sel_e load_sel;
  sel_e free_sel;
  sel_e sel;
  sel_e lock_sel_q;
  logic lock_q;
  logic rr_w_q;
  logic x_rd_q;
  logic w_rd_q;

  // Round robin between the loads, W first when rr_w_q is set
  always_comb begin
    load_sel = SEL_NONE;
    if (x_req_i && w_req_i) begin
      load_sel = rr_w_q ? SEL_W : SEL_X;
    end else if (x_req_i) begin
      load_sel = SEL_X;
    end else if (w_req_i) begin
      load_sel = SEL_W;
    end
  end

  assign free_sel = (z_req_i && (z_priority_i || load_sel == SEL_NONE)) ? SEL_Z : load_sel;

  // A pending request keeps its owner until granted
  assign sel = lock_q ? lock_sel_q : free_sel;

  always_comb begin
    mem_req_o.req   = (sel != SEL_NONE);
    mem_req_o.wen   = (sel != SEL_Z);
    mem_req_o.wdata = z_beat_i.data;
    mem_req_o.be    = (sel == SEL_Z) ? z_beat_i.strb : '1;
    case (sel)
      SEL_W:   mem_req_o.addr = w_addr_i;
      SEL_Z:   mem_req_o.addr = z_addr_i;
      default: mem_req_o.addr = x_addr_i;
    endcase
  end

  assign x_gnt_o = (sel == SEL_X) & mem_rsp_i.gnt;
  assign w_gnt_o = (sel == SEL_W) & mem_rsp_i.gnt;
  assign z_gnt_o = (sel == SEL_Z) & mem_rsp_i.gnt;

  // Read data returns one cycle after the grant
  assign x_rsp_o = x_rd_q & mem_rsp_i.r_valid;
  assign w_rsp_o = w_rd_q & mem_rsp_i.r_valid;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q     <= 1'b0;
      lock_sel_q <= SEL_NONE;
      rr_w_q     <= 1'b0;
      x_rd_q     <= 1'b0;
      w_rd_q     <= 1'b0;
    end else begin
      lock_q     <= mem_req_o.req & ~mem_rsp_i.gnt;
      lock_sel_q <= sel;
      x_rd_q     <= x_gnt_o;
      w_rd_q     <= w_gnt_o;
      if (x_gnt_o) begin
        rr_w_q <= 1'b1;
      end else if (w_gnt_o) begin
        rr_w_q <= 1'b0;
      end
    end
  end

endmodule

// ==== src/load_channel.sv ====
// Load channel buffer with slot reservation and credit-based output to the engine
`timescale 1ns/1ps
`include "streamer_config.svh"

module load_channel
  import streamer_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    clear_i,
  input  logic                    issue_i,
  input  logic                    issue_last_i,
  input  logic                    rsp_valid_i,
  input  logic [`STREAMER_DW-1:0] rsp_data_i,
  output logic                    can_issue_o,
  output load_beat_t              beat_o,
  output logic                    valid_o,
  input  logic                    credit_i,
  output logic                    drained_o
);

  localparam int unsigned SLOT_W = $clog2(`LOAD_FIFO_DEPTH + 1);
  localparam int unsigned CRED_W = $clog2(`ENGINE_CREDITS + 1);

  logic [SLOT_W-1:0] reserved_q;
  logic [CRED_W-1:0] credits_q;
  logic              rsp_last;
  logic              fifo_empty;
  logic              pop;
  load_beat_t        rsp_beat;

  // Last flags in issue order, one per read in flight
  stream_fifo #(
    .T     ( logic            ),
    .DEPTH ( `LOAD_FIFO_DEPTH )
  ) i_last_queue (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .clear_i ( clear_i      ),
    .push_i  ( issue_i      ),
    .data_i  ( issue_last_i ),
    .pop_i   ( rsp_valid_i  ),
    .data_o  ( rsp_last     ),
    .empty_o (              ),
    .full_o  (              )
  );

  assign rsp_beat = '{data: rsp_data_i, last: rsp_last};

  stream_fifo #(
    .T     ( load_beat_t      ),
    .DEPTH ( `LOAD_FIFO_DEPTH )
  ) i_beat_fifo (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .clear_i ( clear_i     ),
    .push_i  ( rsp_valid_i ),
    .data_i  ( rsp_beat    ),
    .pop_i   ( pop         ),
    .data_o  ( beat_o      ),
    .empty_o ( fifo_empty  ),
    .full_o  (             )
  );

  assign valid_o = ~fifo_empty & (credits_q != '0);
  assign pop     = valid_o;

  // A slot counts from its issue until the beat leaves for the engine
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      reserved_q <= '0;
    end else begin
      reserved_q <= reserved_q + SLOT_W'(issue_i) - SLOT_W'(pop);
    end
  end

  // Engine credits carry over from one job to the next
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_q <= CRED_W'(`ENGINE_CREDITS);
    end else begin
      credits_q <= credits_q + CRED_W'(credit_i) - CRED_W'(pop);
    end
  end

  assign can_issue_o = (reserved_q < SLOT_W'(`LOAD_FIFO_DEPTH));
  assign drained_o   = (reserved_q == '0);

endmodule

// ==== src/stream_fifo.sv ====
// Stream FIFO as a circular buffer for any packed payload type
`timescale 1ns/1ps

module stream_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic clear_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o,
  output logic full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== src/stream_addressgen.sv ====
// Stream address generator that walks a strided run of words for one channel
`timescale 1ns/1ps
`include "streamer_config.svh"

module stream_addressgen
  import streamer_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    clear_i,
  input  logic                    run_i,
  input  chan_cfg_t               cfg_i,
  input  logic                    advance_i,
  output logic [`STREAMER_AW-1:0] addr_o,
  output logic                    active_o,
  output logic                    last_o,
  output logic                    finished_o
);

  chan_cfg_t                  cfg_q;
  logic [`STREAMER_LEN_W-1:0] count_q;
  logic [`STREAMER_AW-1:0]    addr_q;

  // Job fields are latched when the channel is cleared
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q   <= '0;
      count_q <= '0;
      addr_q  <= '0;
    end else if (clear_i) begin
      cfg_q   <= cfg_i;
      count_q <= '0;
      addr_q  <= cfg_i.base;
    end else if (advance_i) begin
      count_q <= count_q + 1'b1;
      addr_q  <= addr_q + `STREAMER_AW'(cfg_q.stride);
    end
  end

  assign addr_o   = addr_q;
  assign active_o = run_i & (count_q < cfg_q.len);

  // Never matches for a zero length run
  assign last_o = (cfg_q.len != '0) & (count_q == cfg_q.len - 1'b1);

  assign finished_o = (count_q >= cfg_q.len);

endmodule

// ==== src/streamer_fsm.sv ====
// Streamer job FSM that launches the channels and detects the end of a job
`timescale 1ns/1ps

module streamer_fsm (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  input  logic x_finished_i,
  input  logic w_finished_i,
  input  logic z_finished_i,
  input  logic loads_drained_i,
  output logic run_o,
  output logic clear_o,
  output logic busy_o,
  output logic done_o
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   job_complete;

  // Every address issued and every loaded word handed to the engine
  assign job_complete = x_finished_i & w_finished_i & z_finished_i & loads_drained_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (job_complete) begin
          state_d = DONE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Clear lands on the same edge that enters RUN
  assign clear_o = (state_q == IDLE) & start_i;
  assign run_o   = (state_q == RUN);
  assign busy_o  = (state_q != IDLE);
  assign done_o  = (state_q == DONE);

endmodule

// ==== src/streamer_pkg.sv ====
// Streamer package with job descriptors, stream beats and memory port types
`include "streamer_config.svh"

package streamer_pkg;

  // Strided run of one channel with stride and length counted in words
  typedef struct packed {
    logic [`STREAMER_AW-1:0]    base;
    logic [`STREAMER_LEN_W-1:0] stride;
    logic [`STREAMER_LEN_W-1:0] len;
  } chan_cfg_t;

  typedef struct packed {
    chan_cfg_t x;
    chan_cfg_t w;
    chan_cfg_t z;
    logic      z_priority;
  } streamer_job_t;

  // Beat towards the engine on the X and W streams
  typedef struct packed {
    logic [`STREAMER_DW-1:0] data;
    logic                    last;
  } load_beat_t;

  // Beat from the engine on the Z stream
  typedef struct packed {
    logic [`STREAMER_DW-1:0] data;
    logic [`STREAMER_BW-1:0] strb;
  } store_beat_t;

  // Memory request with wen high for a read and low for a write
  typedef struct packed {
    logic                    req;
    logic                    wen;
    logic [`STREAMER_AW-1:0] addr;
    logic [`STREAMER_DW-1:0] wdata;
    logic [`STREAMER_BW-1:0] be;
  } mem_req_t;

  typedef struct packed {
    logic                    gnt;
    logic                    r_valid;
    logic [`STREAMER_DW-1:0] r_data;
  } mem_rsp_t;

endpackage

// ==== src/streamer_config.svh ====
// Streamer configuration macros for word widths, buffer depths and credit counts
`ifndef STREAMER_CONFIG_SVH
`define STREAMER_CONFIG_SVH

// Data word and byte strobe widths
`define STREAMER_DW 32
`define STREAMER_BW (`STREAMER_DW / 8)

// Word address and job field widths
`define STREAMER_AW 16
`define STREAMER_LEN_W 16

// Slots per load channel
`define LOAD_FIFO_DEPTH 4

// Store FIFO slots matching the Z credits the engine holds after reset
`define STORE_FIFO_DEPTH 2

// Credits the streamer holds per load stream after reset
`define ENGINE_CREDITS 2

`endif
